// ==== logic/ccu_pkg.sv ====
// Shared sizes, line-length encoding and enums imported by every CCU module and the testbench
`default_nettype none

package ccu_pkg;

    // Requestor count where bit 0 wins arbitration
    localparam int NUM_REQ       = 3;
    localparam int REQ_IDX_WIDTH = $clog2(NUM_REQ);

    // Memory word and line geometry
    localparam int WORD_WIDTH = 32;
    localparam int LINE_WORDS = 4;
    localparam int LINE_WIDTH = LINE_WORDS * WORD_WIDTH;

    // Word address into the backing memory
    localparam int ADDR_WIDTH = 8;
    localparam int MEM_WORDS  = 1 << ADDR_WIDTH;

    // A length field holds the number of words minus one
    localparam int LEN_WIDTH = $clog2(LINE_WORDS);

    // Extra cycles inserted ahead of every word transfer
    localparam int WAIT_WIDTH = 3;

    // Width of the configuration write data bus
    localparam int CFG_DATA_WIDTH = 8;

    typedef enum logic {
        CFG_REQ_MASK = 1'b0,
        CFG_WAIT     = 1'b1
    } cfg_reg_e;

    typedef enum logic {
        BIU_FUNC_READ  = 1'b0,
        BIU_FUNC_WRITE = 1'b1
    } biu_func_e;

    typedef enum logic [1:0] {
        ARB_IDLE = 2'b00,
        ARB_BUSY = 2'b01,
        ARB_DONE = 2'b10
    } arb_state_e;

    typedef enum logic [1:0] {
        BIU_IDLE = 2'b00,
        BIU_WAIT = 2'b01,
        BIU_XFER = 2'b10,
        BIU_DONE = 2'b11
    } biu_state_e;

endpackage

`default_nettype wire

// ==== logic/ccu_cfg_regs.sv ====
// Configuration registers for the requestor enable mask and the wait-state count, set by a strobe
`timescale 1ns/1ps
`default_nettype none

module ccu_cfg_regs
    import ccu_pkg::*;
(
    input  logic                      clk,
    input  logic                      i_rst_n,

    // Single-cycle write strobe with no back-pressure
    input  logic                      i_cfg_wr,
    input  cfg_reg_e                  i_cfg_sel,
    input  logic [CFG_DATA_WIDTH-1:0] i_cfg_wdata,

    // Register contents toward the arbiter and the bus interface unit
    output logic [NUM_REQ-1:0]        o_req_mask,
    output logic [WAIT_WIDTH-1:0]     o_wait_cycles
);

    logic mask_wr;
    logic wait_wr;

    // Decode the strobe into one write enable per register
    assign mask_wr = i_cfg_wr && (i_cfg_sel == CFG_REQ_MASK);
    assign wait_wr = i_cfg_wr && (i_cfg_sel == CFG_WAIT);

    // All requestors come out of reset enabled
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_req_mask <= '1;
        end else if (mask_wr) begin
            o_req_mask <= i_cfg_wdata[NUM_REQ-1:0];
        end
    end

    // Zero wait states after reset gives one transfer per cycle
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_wait_cycles <= '0;
        end else if (wait_wr) begin
            o_wait_cycles <= i_cfg_wdata[WAIT_WIDTH-1:0];
        end
    end

    // A strobe must name one of the two registers
    a_cfg_sel_legal: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        i_cfg_wr |-> (!$isunknown(i_cfg_sel) && (i_cfg_sel inside {CFG_REQ_MASK, CFG_WAIT}))
    );

endmodule

`default_nettype wire

// ==== logic/ccu_arb.sv ====
// Fixed-priority arbiter that hands one requestor's line transaction at a time to the BIU
`timescale 1ns/1ps
`default_nettype none

module ccu_arb
    import ccu_pkg::*;
(
    input  logic                  clk,
    input  logic                  i_rst_n,

    // Requestor side where valid is held until done
    input  logic [NUM_REQ-1:0]    i_req_valid,
    input  logic [NUM_REQ-1:0]    i_req_we,
    input  logic [LEN_WIDTH-1:0]  i_req_len  [0:NUM_REQ-1],
    input  logic [ADDR_WIDTH-1:0] i_req_addr [0:NUM_REQ-1],
    input  logic [LINE_WIDTH-1:0] i_req_data [0:NUM_REQ-1],
    input  logic [NUM_REQ-1:0]    i_req_mask,
    output logic [NUM_REQ-1:0]    o_req_grant,
    output logic [NUM_REQ-1:0]    o_req_done,
    output logic [LINE_WIDTH-1:0] o_req_data,

    // Bus interface unit side
    input  logic                  i_biu_done,
    input  logic [LINE_WIDTH-1:0] i_biu_rdata,
    output logic                  o_biu_en,
    output biu_func_e             o_biu_func,
    output logic [LEN_WIDTH-1:0]  o_biu_len,
    output logic [ADDR_WIDTH-1:0] o_biu_addr,
    output logic [LINE_WIDTH-1:0] o_biu_data
);

    arb_state_e               state_r;
    arb_state_e               state_next;
    logic [NUM_REQ-1:0]       masked_valid;
    logic                     any_valid;
    logic [REQ_IDX_WIDTH-1:0] pick_idx;
    logic [REQ_IDX_WIDTH-1:0] idx_r;
    logic [NUM_REQ-1:0]       grant_next;
    logic [NUM_REQ-1:0]       done_next;
    logic                     biu_en_next;

    // Disabled requestors are invisible to the picker
    assign masked_valid = i_req_valid & i_req_mask;
    assign any_valid    = |masked_valid;

    // Walk from the top so the lowest set bit wins
    always_comb begin
        pick_idx = '0;
        for (int i = NUM_REQ - 1; i >= 0; i--) begin
            if (masked_valid[i]) begin
                pick_idx = REQ_IDX_WIDTH'(i);
            end
        end
    end

    // The chosen index is frozen once the FSM leaves idle
    always_ff @(posedge clk) begin
        if (state_r == ARB_IDLE) begin
            idx_r <= pick_idx;
        end
    end

    // Idle picks, busy waits for the BIU, done pulses the requestor for one cycle
    always_comb begin
        state_next  = state_r;
        grant_next  = '0;
        done_next   = '0;
        biu_en_next = 1'b0;
        case (state_r)
            ARB_IDLE: begin
                grant_next[pick_idx] = any_valid;
                if (any_valid) begin
                    state_next = ARB_BUSY;
                end
            end
            ARB_BUSY: begin
                // Follow the held valid so a cleared mask bit cannot abort the transfer
                biu_en_next        = i_biu_done ? 1'b0 : i_req_valid[idx_r];
                done_next[idx_r]   = i_biu_done;
                if (i_biu_done) begin
                    state_next = ARB_DONE;
                end
            end
            ARB_DONE: begin
                state_next = ARB_IDLE;
            end
            default: begin
                state_next = ARB_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state_r     <= ARB_IDLE;
            o_req_grant <= '0;
            o_req_done  <= '0;
            o_biu_en    <= 1'b0;
        end else begin
            state_r     <= state_next;
            o_req_grant <= grant_next;
            o_req_done  <= done_next;
            o_biu_en    <= biu_en_next;
        end
    end

    // Request fields and read data are sampled every cycle
    always_ff @(posedge clk) begin
        o_biu_func <= i_req_we[idx_r] ? BIU_FUNC_WRITE : BIU_FUNC_READ;
        o_biu_len  <= i_req_len[idx_r];
        o_biu_addr <= i_req_addr[idx_r];
        o_biu_data <= i_req_data[idx_r];
        o_req_data <= i_biu_rdata;
    end

    a_grant_onehot: assert property (
        @(posedge clk) disable iff (!i_rst_n) $onehot0(o_req_grant)
    );

    a_done_onehot: assert property (
        @(posedge clk) disable iff (!i_rst_n) $onehot0(o_req_done)
    );

    // Done belongs to the single cycle spent in ARB_DONE
    a_done_in_done_state: assert property (
        @(posedge clk) disable iff (!i_rst_n) (|o_req_done) |-> (state_r == ARB_DONE)
    );

endmodule

`default_nettype wire

// ==== logic/ccu_biu.sv ====
// Bus interface unit that moves one line word by word to or from memory with wait states
`timescale 1ns/1ps
`default_nettype none

module ccu_biu
    import ccu_pkg::*;
(
    input  logic                  clk,
    input  logic                  i_rst_n,

    // Transaction from the arbiter
    input  logic                  i_en,
    input  biu_func_e             i_func,
    input  logic [LEN_WIDTH-1:0]  i_len,
    input  logic [ADDR_WIDTH-1:0] i_addr,
    input  logic [LINE_WIDTH-1:0] i_wdata,
    input  logic [WAIT_WIDTH-1:0] i_wait_cycles,
    output logic                  o_done,
    output logic [LINE_WIDTH-1:0] o_rdata,

    // Memory port
    output logic                  o_mem_we,
    output logic [ADDR_WIDTH-1:0] o_mem_addr,
    output logic [WORD_WIDTH-1:0] o_mem_wdata,
    input  logic [WORD_WIDTH-1:0] i_mem_rdata
);

    biu_state_e              state;
    biu_state_e              word_entry_state;
    logic                    start;
    biu_func_e               func_r;
    logic [LEN_WIDTH-1:0]    len_r;
    logic [ADDR_WIDTH-1:0]   addr_r;
    logic [LINE_WIDTH-1:0]   line_r;
    logic [LEN_WIDTH-1:0]    word_cnt;
    logic [WAIT_WIDTH-1:0]   wait_cnt;
    logic                    rd_pending;
    logic [LEN_WIDTH-1:0]    rd_idx;
    logic [LINE_WIDTH-1:0]   rdata_r;
    logic [LINE_WIDTH-1:0]   rdata_next;

    assign start = (state == BIU_IDLE) && i_en;

    // Each word begins with wait states unless the count is zero
    assign word_entry_state = (i_wait_cycles == '0) ? BIU_XFER : BIU_WAIT;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state      <= BIU_IDLE;
            word_cnt   <= '0;
            wait_cnt   <= '0;
            rd_pending <= 1'b0;
        end else begin
            rd_pending <= (state == BIU_XFER) && (func_r == BIU_FUNC_READ);
            case (state)
                BIU_IDLE: begin
                    if (i_en) begin
                        word_cnt <= '0;
                        wait_cnt <= i_wait_cycles - 1'b1;
                        state    <= word_entry_state;
                    end
                end
                BIU_WAIT: begin
                    if (wait_cnt == '0) begin
                        state <= BIU_XFER;
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                BIU_XFER: begin
                    if (word_cnt == len_r) begin
                        state <= BIU_DONE;
                    end else begin
                        word_cnt <= word_cnt + 1'b1;
                        wait_cnt <= i_wait_cycles - 1'b1;
                        state    <= word_entry_state;
                    end
                end
                default: begin
                    state <= BIU_IDLE;
                end
            endcase
        end
    end

    // Merge the word returned by memory into the line being assembled
    always_comb begin
        rdata_next = rdata_r;
        if (rd_pending) begin
            rdata_next[rd_idx*WORD_WIDTH +: WORD_WIDTH] = i_mem_rdata;
        end
    end

    // The read line starts from zero so words beyond the length stay clear
    always_ff @(posedge clk) begin
        if (start) begin
            func_r  <= i_func;
            len_r   <= i_len;
            addr_r  <= i_addr;
            line_r  <= i_wdata;
            rdata_r <= '0;
        end else begin
            rdata_r <= rdata_next;
        end
        rd_idx <= word_cnt;
    end

    assign o_done      = (state == BIU_DONE);
    assign o_rdata     = rdata_next;
    assign o_mem_we    = (state == BIU_XFER) && (func_r == BIU_FUNC_WRITE);
    assign o_mem_addr  = addr_r + {{(ADDR_WIDTH-LEN_WIDTH){1'b0}}, word_cnt};
    assign o_mem_wdata = line_r[word_cnt*WORD_WIDTH +: WORD_WIDTH];

    // Writes happen only in a transfer cycle and never past the requested length
    a_mem_we_in_xfer: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        o_mem_we |-> ((state == BIU_XFER) && (word_cnt <= len_r))
    );

endmodule

`default_nettype wire

// ==== logic/ccu_line_mem.sv ====
// Word-wide backing memory with one synchronous read/write port behind the BIU
`timescale 1ns/1ps
`default_nettype none

module ccu_line_mem
    import ccu_pkg::*;
(
    input  logic                  clk,
    input  logic                  i_we,
    input  logic [ADDR_WIDTH-1:0] i_addr,
    input  logic [WORD_WIDTH-1:0] i_wdata,
    output logic [WORD_WIDTH-1:0] o_rdata
);

    logic [WORD_WIDTH-1:0] mem [0:MEM_WORDS-1];

    // Write on the edge
    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_addr] <= i_wdata;
        end
    end

    // Read data appears the cycle after the address and shows
    // the old contents when the same word is written in that cycle
    always_ff @(posedge clk) begin
        o_rdata <= mem[i_addr];
    end

endmodule

`default_nettype wire

// ==== logic/ccu_top.sv ====
// CCU top level tying the configuration registers, arbiter, BIU and backing memory together
`timescale 1ns/1ps
`default_nettype none

module ccu_top
    import ccu_pkg::*;
(
    input  logic                      clk,
    input  logic                      i_rst_n,

    // Configuration strobe
    input  logic                      i_cfg_wr,
    input  cfg_reg_e                  i_cfg_sel,
    input  logic [CFG_DATA_WIDTH-1:0] i_cfg_wdata,

    // Requestors
    input  logic [NUM_REQ-1:0]        i_req_valid,
    input  logic [NUM_REQ-1:0]        i_req_we,
    input  logic [LEN_WIDTH-1:0]      i_req_len  [0:NUM_REQ-1],
    input  logic [ADDR_WIDTH-1:0]     i_req_addr [0:NUM_REQ-1],
    input  logic [LINE_WIDTH-1:0]     i_req_data [0:NUM_REQ-1],
    output logic [NUM_REQ-1:0]        o_req_grant,
    output logic [NUM_REQ-1:0]        o_req_done,
    output logic [LINE_WIDTH-1:0]     o_req_data
);

    logic [NUM_REQ-1:0]    req_mask;
    logic [WAIT_WIDTH-1:0] wait_cycles;
    logic                  biu_en;
    biu_func_e             biu_func;
    logic [LEN_WIDTH-1:0]  biu_len;
    logic [ADDR_WIDTH-1:0] biu_addr;
    logic [LINE_WIDTH-1:0] biu_data;
    logic                  biu_done;
    logic [LINE_WIDTH-1:0] biu_rdata;
    logic                  mem_we;
    logic [ADDR_WIDTH-1:0] mem_addr;
    logic [WORD_WIDTH-1:0] mem_wdata;
    logic [WORD_WIDTH-1:0] mem_rdata;

    ccu_cfg_regs u_cfg (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_cfg_wr      (i_cfg_wr),
        .i_cfg_sel     (i_cfg_sel),
        .i_cfg_wdata   (i_cfg_wdata),
        .o_req_mask    (req_mask),
        .o_wait_cycles (wait_cycles)
    );

    ccu_arb u_arb (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_req_valid (i_req_valid),
        .i_req_we    (i_req_we),
        .i_req_len   (i_req_len),
        .i_req_addr  (i_req_addr),
        .i_req_data  (i_req_data),
        .i_req_mask  (req_mask),
        .o_req_grant (o_req_grant),
        .o_req_done  (o_req_done),
        .o_req_data  (o_req_data),
        .i_biu_done  (biu_done),
        .i_biu_rdata (biu_rdata),
        .o_biu_en    (biu_en),
        .o_biu_func  (biu_func),
        .o_biu_len   (biu_len),
        .o_biu_addr  (biu_addr),
        .o_biu_data  (biu_data)
    );

    ccu_biu u_biu (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_en          (biu_en),
        .i_func        (biu_func),
        .i_len         (biu_len),
        .i_addr        (biu_addr),
        .i_wdata       (biu_data),
        .i_wait_cycles (wait_cycles),
        .o_done        (biu_done),
        .o_rdata       (biu_rdata),
        .o_mem_we      (mem_we),
        .o_mem_addr    (mem_addr),
        .o_mem_wdata   (mem_wdata),
        .i_mem_rdata   (mem_rdata)
    );

    ccu_line_mem u_mem (
        .clk     (clk),
        .i_we    (mem_we),
        .i_addr  (mem_addr),
        .i_wdata (mem_wdata),
        .o_rdata (mem_rdata)
    );

endmodule

`default_nettype wire

// ==== dv/ccu_tb.sv ====
// CCU testbench that replays the case file through the DUT and checks it, run by make test
`timescale 1ns/1ps
`default_nettype none

module ccu_tb
    import ccu_pkg::*;
();

    logic                      clk = 1'b0;
    logic                      rst_n;
    logic                      cfg_wr;
    cfg_reg_e                  cfg_sel;
    logic [CFG_DATA_WIDTH-1:0] cfg_wdata;
    logic [NUM_REQ-1:0]        req_valid;
    logic [NUM_REQ-1:0]        req_we;
    logic [LEN_WIDTH-1:0]      req_len  [0:NUM_REQ-1];
    logic [ADDR_WIDTH-1:0]     req_addr [0:NUM_REQ-1];
    logic [LINE_WIDTH-1:0]     req_data [0:NUM_REQ-1];
    logic [NUM_REQ-1:0]        req_grant;
    logic [NUM_REQ-1:0]        req_done;
    logic [LINE_WIDTH-1:0]     req_rdata;

    // Case file contents with one value per entry
    logic [LINE_WIDTH-1:0]     cases_mem [0:255];
    logic [NUM_REQ-1:0]        mask_model;
    int                        seed;
    int                        error_count = 0;
    int                        check_count = 0;
    int                        group_count = 0;
    int                        cycle_count = 0;
    int                        cycle_limit = 480;

    ccu_top u_dut (
        .clk         (clk),
        .i_rst_n     (rst_n),
        .i_cfg_wr    (cfg_wr),
        .i_cfg_sel   (cfg_sel),
        .i_cfg_wdata (cfg_wdata),
        .i_req_valid (req_valid),
        .i_req_we    (req_we),
        .i_req_len   (req_len),
        .i_req_addr  (req_addr),
        .i_req_data  (req_data),
        .o_req_grant (req_grant),
        .o_req_done  (req_done),
        .o_req_data  (req_rdata)
    );

    always #5 clk = ~clk;

    // Stops a hung run at a limit scaled by the number of request groups
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic report_error(input string msg);
        error_count++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    // One strobe cycle whose value the register takes on the second edge
    task automatic write_cfg(input cfg_reg_e sel, input logic [CFG_DATA_WIDTH-1:0] data);
        @(posedge clk);
        cfg_wr    <= 1'b1;
        cfg_sel   <= sel;
        cfg_wdata <= data;
        @(posedge clk);
        cfg_wr    <= 1'b0;
        if (sel == CFG_REQ_MASK) begin
            mask_model = data[NUM_REQ-1:0];
        end
    endtask

    task automatic check_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_count++;
            assert (req_grant == '0 && req_done == '0)
                else report_error($sformatf("grant %b or done %b high while idle",
                                            req_grant, req_done));
        end
    endtask

    // Walks the case entries the same way the main loop does
    function automatic int count_groups();
        int p;
        int n;
        p = 0;
        n = 0;
        while (p < 235 && cases_mem[p][3:0] != 4'hf) begin
            if (cases_mem[p][3:0] == 4'h1) begin
                n++;
                p += 3 + NUM_REQ * 6;
            end else begin
                p += 3;
            end
        end
        return n;
    endfunction

    task automatic run_group(input int base);
        logic [NUM_REQ-1:0]    listed;
        logic [NUM_REQ-1:0]    is_write;
        logic [NUM_REQ-1:0]    pending;
        logic [NUM_REQ-1:0]    granted;
        logic [NUM_REQ-1:0]    drop;
        logic [LINE_WIDTH-1:0] exp_line [0:NUM_REQ-1];
        int                    order [$];
        int                    expected [$];
        int                    row;
        int                    wait_val;

        wait_val = $random(seed) & 7;
        write_cfg(CFG_WAIT, CFG_DATA_WIDTH'(wait_val));

        @(posedge clk);
        for (int i = 0; i < NUM_REQ; i++) begin
            row         = base + i * 6;
            listed[i]   = cases_mem[row][0];
            is_write[i] = cases_mem[row + 1][0];
            exp_line[i] = cases_mem[row + 5];
            req_we[i]   <= cases_mem[row + 1][0];
            req_len[i]  <= cases_mem[row + 2][LEN_WIDTH-1:0];
            req_addr[i] <= cases_mem[row + 3][ADDR_WIDTH-1:0];
            req_data[i] <= cases_mem[row + 4];
        end
        req_valid <= listed;

        // Enabled requestors go first by index and masked ones follow once the mask reopens
        for (int i = 0; i < NUM_REQ; i++) begin
            if (listed[i] && mask_model[i]) begin
                expected.push_back(i);
            end
        end
        for (int i = 0; i < NUM_REQ; i++) begin
            if (listed[i] && !mask_model[i]) begin
                expected.push_back(i);
            end
        end

        pending = listed;
        granted = '0;
        while (pending != '0) begin
            @(negedge clk);
            drop = '0;
            for (int i = 0; i < NUM_REQ; i++) begin
                if (req_grant[i]) begin
                    check_count++;
                    assert (listed[i] && mask_model[i] && !granted[i])
                        else report_error($sformatf("unexpected grant to requestor %0d", i));
                    granted[i] = 1'b1;
                    order.push_back(i);
                end
                if (req_done[i]) begin
                    check_count++;
                    assert (pending[i] && granted[i])
                        else report_error($sformatf("done to requestor %0d without its grant", i));
                    if (!is_write[i]) begin
                        check_count++;
                        assert (req_rdata == exp_line[i])
                            else report_error($sformatf("requestor %0d read %h, expected %h",
                                                        i, req_rdata, exp_line[i]));
                    end
                    pending[i] = 1'b0;
                    drop[i]    = 1'b1;
                end
            end
            @(posedge clk);
            for (int i = 0; i < NUM_REQ; i++) begin
                if (drop[i]) begin
                    req_valid[i] <= 1'b0;
                end
            end
            // Only masked requestors are left waiting
            if (pending != '0 && (pending & mask_model) == '0) begin
                write_cfg(CFG_REQ_MASK, '1);
            end
        end

        check_count++;
        assert (order.size() == expected.size())
            else report_error($sformatf("%0d grants seen, expected %0d",
                                        order.size(), expected.size()));
        for (int k = 0; k < order.size() && k < expected.size(); k++) begin
            check_count++;
            assert (order[k] == expected[k])
                else report_error($sformatf("grant %0d went to requestor %0d, expected %0d",
                                            k, order[k], expected[k]));
        end
        group_count++;
    endtask

    initial begin
        int         ptr;
        int         group_total;
        logic [3:0] kind;
        logic       stop;

        seed        = 32'hb464;
        mask_model  = '1;
        rst_n       <= 1'b0;
        cfg_wr      <= 1'b0;
        cfg_sel     <= CFG_REQ_MASK;
        cfg_wdata   <= '0;
        req_valid   <= '0;
        req_we      <= '0;
        for (int i = 0; i < NUM_REQ; i++) begin
            req_len[i]  <= '0;
            req_addr[i] <= '0;
            req_data[i] <= '0;
        end

        $readmemh("dv/ccu_cases.txt", cases_mem);
        group_total = count_groups();
        cycle_limit = (group_total > 0 ? group_total : 1) * 3 * 160;

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        check_quiet(4);

        ptr  = 0;
        stop = 1'b0;
        while (!stop && ptr < 235) begin
            kind = cases_mem[ptr][3:0];
            if (kind == 4'hf) begin
                stop = 1'b1;
            end else if (kind == 4'h0) begin
                write_cfg(cfg_reg_e'(cases_mem[ptr + 1][0]),
                          cases_mem[ptr + 2][CFG_DATA_WIDTH-1:0]);
                ptr += 3;
            end else if (kind == 4'h1) begin
                run_group(ptr + 3);
                ptr += 3 + NUM_REQ * 6;
            end else begin
                $display("The case file holds an unknown row kind at entry %0d", ptr);
                error_count++;
                stop = 1'b1;
            end
        end

        if (group_count == 0) begin
            $display("No request groups were read from the case file");
            error_count++;
        end

        $display("Summary: %0d groups, %0d checks, %0d errors",
                 group_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/ccu_cases.txt ====
// Row header: kind (0 config write, 1 request group, f end) cfg_sel cfg_wdata
// A group header is followed by one line per requestor 0..2: valid we len addr data expected_read_line
1 0 00
1 1 3 10 a1a1a1a3a1a1a1a2a1a1a1a1a1a1a1a0 0
1 1 3 20 b2b2b2b3b2b2b2b2b2b2b2b1b2b2b2b0 0
1 0 3 10 0 a1a1a1a3a1a1a1a2a1a1a1a1a1a1a1a0
1 0 00
1 0 3 20 0 b2b2b2b3b2b2b2b2b2b2b2b1b2b2b2b0
1 0 3 10 0 a1a1a1a3a1a1a1a2a1a1a1a1a1a1a1a0
0 0 0 00 0 0
1 0 00
1 1 1 20 d4d4d4d3d4d4d4d2d4d4d4d1d4d4d4d0 0
1 0 1 10 0 0000000000000000a1a1a1a1a1a1a1a0
1 0 3 20 0 b2b2b2b3b2b2b2b2d4d4d4d1d4d4d4d0
0 0 05
1 0 00
1 0 3 10 0 a1a1a1a3a1a1a1a2a1a1a1a1a1a1a1a0
1 0 2 20 0 00000000b2b2b2b2d4d4d4d1d4d4d4d0
1 1 3 30 c3c3c3c3c3c3c3c2c3c3c3c1c3c3c3c0 0
1 0 00
1 0 3 30 0 c3c3c3c3c3c3c3c2c3c3c3c1c3c3c3c0
1 0 0 20 0 000000000000000000000000d4d4d4d0
1 0 2 11 0 00000000a1a1a1a3a1a1a1a2a1a1a1a1
f 0 00

// ==== sources.f ====
logic/ccu_pkg.sv
logic/ccu_cfg_regs.sv
logic/ccu_arb.sv
logic/ccu_biu.sv
logic/ccu_line_mem.sv
logic/ccu_top.sv
dv/ccu_tb.sv

// ==== Makefile ====
SIM := obj_dir/ccu_sim

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module ccu_tb -f sources.f -o ccu_sim
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf obj_dir
